// ==== rtl/huff_sram_consts.svh ====
`ifndef HUFF_SRAM_CONSTS_SVH
`define HUFF_SRAM_CONSTS_SVH

// byte bases of the three sram regions
`define HUFF_BASE_HIST 32'h33000000
`define HUFF_BASE_NODE 32'h33001024  // odd value kept for map compatibility
`define HUFF_BASE_PATH 32'h33003072

// region sizes
`define HUFF_HIST_ENTRIES 256
`define HUFF_NODE_WORDS 2   // high word first
`define HUFF_PATH_WORDS 4

// beat fifo between generator and bus master
`define HUFF_FIFO_DEPTH 4

`endif

// ==== rtl/huff_sram_pkg.sv ====
package huff_sram_pkg;

    // client operation codes
    typedef enum logic [2:0] {
        HIST_CLEAR = 3'd0,
        HIST_WR    = 3'd1,
        HIST_RD    = 3'd2,
        NODE_WR    = 3'd3,
        NODE_RD    = 3'd4,
        PATH_WR    = 3'd5,
        PATH_RD    = 3'd6
    } huff_op_e;

    // tree node, two sram words
    typedef struct packed {
        logic [17:0] rsvd;
        logic [6:0]  left;   // left child index
        logic [6:0]  right;  // right child index
        logic [31:0] weight;
    } huff_node_t;

    typedef struct packed {
        logic [63:0] pad;
        huff_node_t  entry;
    } huff_node_view_t;

    typedef struct packed {
        logic [95:0] pad;
        logic [31:0] count;
    } huff_hist_view_t;

    // one 128 bit word, seen three ways
    typedef union packed {
        logic [0:3][31:0] path;  // word 0 is the top word
        huff_node_view_t  node;
        huff_hist_view_t  hist;
    } huff_payload_u;

    typedef struct packed {
        huff_op_e      op;
        logic [7:0]    idx;
        huff_payload_u wdata;
    } huff_req_t;

    // single word bus transaction
    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [1:0]  slot;  // word position in payload
        logic        last;
    } huff_beat_t;

endpackage

// ==== rtl/huff_beat_gen.sv ====
`timescale 1ns/1ns
`include "huff_sram_consts.svh"

module huff_beat_gen import huff_sram_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_i,
    input  huff_req_t  req_s_i,
    output logic       ack_o,
    output huff_beat_t beat_o,
    output logic       push_o,
    input  logic       full_i,
    input  logic       done_i
);

    localparam logic [1:0] GEN_IDLE = 2'd0;
    localparam logic [1:0] GEN_RUN  = 2'd1;
    localparam logic [1:0] GEN_WAIT = 2'd2;
    localparam logic [1:0] GEN_ACK  = 2'd3;

    logic [1:0]  state;
    logic [7:0]  cnt;       // beat index within request
    logic [7:0]  last_idx;
    huff_req_t   req_q;
    logic [31:0] base;
    logic [31:0] word_off;
    logic [1:0]  slot;
    logic        is_wr;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= GEN_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                GEN_IDLE: begin
                    if (req_i) begin
                        state <= GEN_RUN;
                        cnt   <= '0;
                    end
                end
                GEN_RUN: begin
                    if (push_o) begin
                        cnt <= cnt + 8'd1;
                        if (cnt == last_idx) state <= GEN_WAIT;
                    end
                end
                GEN_WAIT: if (done_i) state <= GEN_ACK;  // last beat is on the bus
                GEN_ACK:  if (!req_i) state <= GEN_IDLE;
                default:  state <= GEN_IDLE;
            endcase
        end
    end

    // request held stable by client, latched once
    always_ff @(posedge clk) begin
        if (state == GEN_IDLE && req_i) req_q <= req_s_i;
    end

    // region, word offset and payload slot per operation
    always_comb begin
        base     = `HUFF_BASE_HIST;
        word_off = {24'd0, req_q.idx};
        slot     = 2'd3;
        last_idx = '0;
        is_wr    = 1'b0;
        case (req_q.op)
            HIST_CLEAR: begin
                word_off = {24'd0, cnt};
                last_idx = 8'(`HUFF_HIST_ENTRIES - 1);
                is_wr    = 1'b1;
            end
            HIST_WR: is_wr = 1'b1;
            HIST_RD: is_wr = 1'b0;
            NODE_WR, NODE_RD: begin
                base     = `HUFF_BASE_NODE;
                word_off = {23'd0, req_q.idx, cnt[0]};
                slot     = {1'b1, cnt[0]};  // node sits in words 2 and 3
                last_idx = 8'(`HUFF_NODE_WORDS - 1);
                is_wr    = (req_q.op == NODE_WR);
            end
            PATH_WR, PATH_RD: begin
                base     = `HUFF_BASE_PATH;
                word_off = {22'd0, req_q.idx, cnt[1:0]};
                slot     = cnt[1:0];
                last_idx = 8'(`HUFF_PATH_WORDS - 1);
                is_wr    = (req_q.op == PATH_WR);
            end
            default: ;
        endcase
    end

    assign beat_o.wr    = is_wr;
    assign beat_o.addr  = base + {word_off[29:0], 2'b00};
    assign beat_o.wdata = (req_q.op == HIST_CLEAR) ? 32'd0 : req_q.wdata.path[slot];
    assign beat_o.slot  = slot;
    assign beat_o.last  = (cnt == last_idx);

    assign push_o = (state == GEN_RUN) && !full_i;
    assign ack_o  = (state == GEN_ACK);

endmodule

// ==== rtl/huff_beat_fifo.sv ====
`timescale 1ns/1ns

module huff_beat_fifo import huff_sram_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  huff_beat_t beat_i,
    input  logic       push_i,
    output logic       full_o,
    output huff_beat_t beat_o,
    input  logic       pop_i,
    output logic       empty_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    huff_beat_t    mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_push;
    logic          do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= beat_i;
    end

    assign beat_o  = mem[rd_ptr];  // head, valid while not empty
    assign full_o  = (count == CW'(DEPTH));
    assign empty_o = (count == '0);

endmodule

// ==== rtl/huff_bus_master.sv ====
`timescale 1ns/1ns

module huff_bus_master import huff_sram_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  huff_beat_t    beat_i,
    input  logic          empty_i,
    output logic          pop_o,
    output logic          wr_en_o,
    output logic          r_en_o,
    output logic [31:0]   addr_o,
    output logic [31:0]   wdata_o,
    input  logic          busy_i,
    input  logic [31:0]   rdata_i,
    output huff_payload_u resp_o,
    output logic          done_o
);

    localparam logic [1:0] M_IDLE   = 2'd0;
    localparam logic [1:0] M_STROBE = 2'd1;
    localparam logic [1:0] M_WAIT   = 2'd2;

    logic [1:0] state;
    logic       busy_q;  // busy one cycle back
    logic       busy_fall;
    logic       complete;

    assign busy_fall = busy_q && !busy_i;
    assign complete  = (state == M_WAIT) && busy_fall;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= M_IDLE;
            busy_q <= 1'b0;
        end else begin
            busy_q <= busy_i;
            case (state)
                M_IDLE: begin
                    if (!empty_i) state <= M_STROBE;
                end
                M_STROBE: begin
                    // memory took the request, drop the strobe
                    if (busy_i) state <= M_WAIT;
                end
                M_WAIT: begin
                    if (busy_fall) state <= M_IDLE;
                end
                default: state <= M_IDLE;
            endcase
        end
    end

    // read words land in the slot the beat names
    always_ff @(posedge clk) begin
        if (complete && !beat_i.wr) resp_o.path[beat_i.slot] <= rdata_i;
    end

    // fifo head stays put until popped, so the bus fields are stable
    assign addr_o  = beat_i.addr;
    assign wdata_o = beat_i.wdata;
    assign wr_en_o = (state == M_STROBE) && beat_i.wr;
    assign r_en_o  = (state == M_STROBE) && !beat_i.wr;

    assign pop_o  = complete;
    assign done_o = complete && beat_i.last;  // end of the whole request

endmodule

// ==== rtl/huff_sram_top.sv ====
`timescale 1ns/1ns
`include "huff_sram_consts.svh"

module huff_sram_top import huff_sram_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    // client, four phase
    input  logic          req_i,
    input  huff_req_t     req_s_i,
    output logic          ack_o,
    output huff_payload_u resp_o,
    // sram bus
    output logic          wr_en_o,
    output logic          r_en_o,
    output logic [31:0]   addr_o,
    output logic [31:0]   wdata_o,
    input  logic          busy_i,
    input  logic [31:0]   rdata_i
);

    huff_beat_t gen_beat;
    huff_beat_t head_beat;
    logic       push;
    logic       full;
    logic       pop;
    logic       empty;
    logic       done;

    huff_beat_gen gen_i (
        .clk     (clk),
        .rst     (rst),
        .req_i   (req_i),
        .req_s_i (req_s_i),
        .ack_o   (ack_o),
        .beat_o  (gen_beat),
        .push_o  (push),
        .full_i  (full),
        .done_i  (done)
    );

    huff_beat_fifo #(
        .DEPTH (`HUFF_FIFO_DEPTH)
    ) fifo_i (
        .clk     (clk),
        .rst     (rst),
        .beat_i  (gen_beat),
        .push_i  (push),
        .full_o  (full),
        .beat_o  (head_beat),
        .pop_i   (pop),
        .empty_o (empty)
    );

    huff_bus_master master_i (
        .clk     (clk),
        .rst     (rst),
        .beat_i  (head_beat),
        .empty_i (empty),
        .pop_o   (pop),
        .wr_en_o (wr_en_o),
        .r_en_o  (r_en_o),
        .addr_o  (addr_o),
        .wdata_o (wdata_o),
        .busy_i  (busy_i),
        .rdata_i (rdata_i),
        .resp_o  (resp_o),
        .done_o  (done)
    );

endmodule

// ==== test/huff_sram_mem_model.sv ====
`timescale 1ns/1ns
`include "huff_sram_consts.svh"

module huff_sram_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_en_i,
    input  logic        r_en_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    input  logic [7:0]  node_idx_i,  // node the client is working on
    output logic        busy_o,
    output logic [31:0] rdata_o,
    output logic        node_chk_o,
    output logic [31:0] node_exp_o,
    output logic [31:0] node_got_o
);

    localparam int WORDS = 8192;  // covers all three regions

    logic [31:0] mem [WORDS];
    logic [31:0] lfsr_q = 32'h22d9;
    logic [1:0]  phase;  // 0 idle, 1 delay, 2 busy
    logic [2:0]  cnt;
    logic        op_wr;
    logic [31:0] op_addr;
    logic [31:0] op_wdata;
    logic        node_k;  // high or low word of the node

    function automatic logic [31:0] step_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [3:0] take_bits(input int n);
        logic [3:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = step_lfsr(lfsr_q);
            v = {v[2:0], lfsr_q[0]};
        end
        return v;
    endfunction

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = (`HUFF_BASE_HIST + 32'(4 * i)) ^ 32'hc3a5_5a3c;
        end
    end

    always @(negedge clk or posedge rst) begin
        if (rst) begin
            phase      <= 2'd0;
            cnt        <= '0;
            busy_o     <= 1'b0;
            rdata_o    <= '0;
            node_chk_o <= 1'b0;
            node_k     <= 1'b0;
        end else begin
            node_chk_o <= 1'b0;
            case (phase)
                2'd0: begin
                    if (wr_en_i || r_en_i) begin
                        op_wr    <= wr_en_i;
                        op_addr  <= addr_i;
                        op_wdata <= wdata_i;
                        cnt      <= 3'(1 + (take_bits(2) % 3));
                        phase    <= 2'd1;
                        if (addr_i >= `HUFF_BASE_NODE &&
                            addr_i < `HUFF_BASE_NODE + 4 * `HUFF_NODE_WORDS * 256) begin
                            node_chk_o <= 1'b1;
                            node_got_o <= addr_i;
                            node_exp_o <= `HUFF_BASE_NODE + {21'd0, node_idx_i, node_k, 2'b00};
                            node_k     <= !node_k;
                        end
                    end
                end
                2'd1: begin
                    if (cnt == 3'd1) begin
                        busy_o <= 1'b1;
                        cnt    <= 3'(1 + take_bits(2));  // busy length 1 to 4
                        phase  <= 2'd2;
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                end
                default: begin
                    if (cnt == 3'd1) begin
                        busy_o <= 1'b0;
                        phase  <= 2'd0;
                        if (op_wr) mem[op_addr[14:2]] <= op_wdata;
                        else rdata_o <= mem[op_addr[14:2]];  // ready as busy falls
                    end else begin
                        cnt <= cnt - 3'd1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== test/huff_sram_tb.sv ====
`timescale 1ns/1ns
`include "huff_sram_consts.svh"

module huff_sram_tb import huff_sram_pkg::*; ();

    localparam int MAX_CYCLES = 300 * 10;

    logic          clk;
    logic          rst;
    logic          req;
    huff_req_t     req_s;
    logic          ack;
    huff_payload_u resp;
    logic          wr_en;
    logic          r_en;
    logic [31:0]   addr;
    logic [31:0]   wdata;
    logic          busy;
    logic [31:0]   rdata;
    logic [7:0]    node_idx;
    logic          node_chk;
    logic [31:0]   node_exp;
    logic [31:0]   node_got;
    logic [31:0]   lfsr_q = 32'h22d9;
    int            cycles = 0;
    huff_payload_u got;  // resp_o taken while ack_o is high

    huff_sram_top dut_i (
        .clk     (clk),
        .rst     (rst),
        .req_i   (req),
        .req_s_i (req_s),
        .ack_o   (ack),
        .resp_o  (resp),
        .wr_en_o (wr_en),
        .r_en_o  (r_en),
        .addr_o  (addr),
        .wdata_o (wdata),
        .busy_i  (busy),
        .rdata_i (rdata)
    );

    huff_sram_mem_model mem_i (
        .clk        (clk),
        .rst        (rst),
        .wr_en_i    (wr_en),
        .r_en_i     (r_en),
        .addr_i     (addr),
        .wdata_i    (wdata),
        .node_idx_i (node_idx),
        .busy_o     (busy),
        .rdata_o    (rdata),
        .node_chk_o (node_chk),
        .node_exp_o (node_exp),
        .node_got_o (node_got)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] step_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_q = step_lfsr(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // path base is not a multiple of four, so words count from the region base
    function automatic logic addr_in_map(input logic [31:0] a);
        logic [31:0] off;
        logic        hit;
        off = '0;
        hit = 1'b0;
        if (a >= `HUFF_BASE_HIST && a < `HUFF_BASE_HIST + 4 * `HUFF_HIST_ENTRIES) begin
            off = a - `HUFF_BASE_HIST;
            hit = 1'b1;
        end else if (a >= `HUFF_BASE_NODE &&
                     a < `HUFF_BASE_NODE + 4 * `HUFF_NODE_WORDS * 256) begin
            off = a - `HUFF_BASE_NODE;
            hit = 1'b1;
        end else if (a >= `HUFF_BASE_PATH &&
                     a < `HUFF_BASE_PATH + 4 * `HUFF_PATH_WORDS * 256) begin
            off = a - `HUFF_BASE_PATH;
            hit = 1'b1;
        end
        return hit && (off[1:0] == 2'b00);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string name, input logic [127:0] exp,
                                 input logic [127:0] act);
        abort_run($sformatf("mismatch at %0t ns: %s expected %h got %h",
                            $time, name, exp, act));
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        assert (act === exp) else flag_mismatch(name, exp, act);
    endtask

    // one full four phase handshake
    task automatic run_request(input huff_op_e op, input logic [7:0] idx,
                               input huff_payload_u wd);
        @(negedge clk);
        req_s.op    = op;
        req_s.idx   = idx;
        req_s.wdata = wd;
        req         = 1'b1;
        do @(negedge clk); while (!ack);
        got = resp;
        req = 1'b0;
        do @(negedge clk); while (ack);
    endtask

    assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
        else abort_run("ack_o rose without a request on req_i");
    assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> $past(!req))
        else abort_run("ack_o fell while req_i was still high");
    assert property (@(posedge clk) disable iff (rst) !(wr_en && r_en))
        else abort_run("wr_en_o and r_en_o were high together");
    assert property (@(posedge clk) disable iff (rst)
                     (wr_en || r_en) && !busy |=> addr == $past(addr))
        else abort_run("addr_o changed while the strobe waited for busy_i");
    assert property (@(posedge clk) disable iff (rst) (wr_en || r_en) |-> addr_in_map(addr))
        else abort_run("addr_o not word aligned or outside the three regions");
    assert property (@(posedge clk) disable iff (rst) node_chk |-> node_got == node_exp)
        else flag_mismatch("addr_o node word", node_exp, node_got);

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) abort_run("timeout, the client handshake never finished");
    end

    initial begin
        huff_payload_u wd;
        huff_payload_u path_a;
        huff_payload_u path_b;
        huff_node_t    nd;
        logic [7:0]    e;
        logic [7:0]    p;
        rst      = 1'b1;
        req      = 1'b0;
        req_s    = '0;
        node_idx = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // clear, then spot check entries
        run_request(HIST_CLEAR, 8'd0, '0);
        repeat (4) begin
            run_request(HIST_RD, 8'(rand_bits(8)), '0);
            check_word("resp_o.hist.count", 32'd0, got.hist.count);
        end

        e = 8'(rand_bits(8));
        wd = '0;
        wd.hist.count = rand_bits(32);
        run_request(HIST_WR, e, wd);
        run_request(HIST_RD, e, '0);
        check_word("resp_o.hist.count", wd.hist.count, got.hist.count);
        run_request(HIST_RD, e + 8'd1, '0);  // neighbour never written
        check_word("resp_o.hist.count", 32'd0, got.hist.count);

        nd.rsvd   = '0;
        nd.left   = 7'(rand_bits(7));
        nd.right  = 7'(rand_bits(7));
        nd.weight = rand_bits(32);
        wd = '0;
        wd.node.entry = nd;
        node_idx = 8'(rand_bits(8));
        run_request(NODE_WR, node_idx, wd);
        run_request(NODE_RD, node_idx, '0);
        check_word("resp_o.node.left", 32'(nd.left), 32'(got.node.entry.left));
        check_word("resp_o.node.right", 32'(nd.right), 32'(got.node.entry.right));
        check_word("resp_o.node.weight", nd.weight, got.node.entry.weight);

        p = 8'(rand_bits(8));
        for (int k = 0; k < 4; k++) begin
            path_a.path[k] = rand_bits(32);
            path_b.path[k] = rand_bits(32);
        end
        run_request(PATH_WR, p, path_a);
        run_request(PATH_WR, p ^ 8'h5a, path_b);
        run_request(PATH_RD, p, '0);
        for (int k = 0; k < 4; k++) begin
            check_word($sformatf("resp_o.path[%0d]", k), path_a.path[k], got.path[k]);
        end
        run_request(PATH_RD, p ^ 8'h5a, '0);
        for (int k = 0; k < 4; k++) begin
            check_word($sformatf("resp_o.path[%0d]", k), path_b.path[k], got.path[k]);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== huff_sram.f ====
+incdir+rtl
rtl/huff_sram_pkg.sv
rtl/huff_beat_gen.sv
rtl/huff_beat_fifo.sv
rtl/huff_bus_master.sv
rtl/huff_sram_top.sv
test/huff_sram_mem_model.sv
test/huff_sram_tb.sv

// ==== Bender.yml ====
package:
  name: huff_sram

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/huff_sram_pkg.sv
      - rtl/huff_beat_gen.sv
      - rtl/huff_beat_fifo.sv
      - rtl/huff_bus_master.sv
      - rtl/huff_sram_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/huff_sram_mem_model.sv
      - test/huff_sram_tb.sv
